// ==== verilog/ifu_macros.svh ====
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// width of fetch addresses and instruction words.
`define IFU_XLEN 32

// first fetch address after reset.
`define IFU_PC_INIT 32'h8000_0000

// log2 of the number of cache sets.
`define L1I_SET_BITS 2

// log2 of the number of words in one cache line.
`define L1I_WORD_BITS 1

// derived cache geometry.
`define L1I_SETS (1 << `L1I_SET_BITS)
`define L1I_WORDS (1 << `L1I_WORD_BITS)

// tag covers what is left above index, word offset and byte offset.
`define L1I_TAG_BITS (`IFU_XLEN - `L1I_SET_BITS - `L1I_WORD_BITS - 2)

// bit position where the set index starts.
`define L1I_IDX_LSB (`L1I_WORD_BITS + 2)

// bit position where the tag starts.
`define L1I_TAG_LSB (`L1I_IDX_LSB + `L1I_SET_BITS)

`endif

// ==== verilog/rv_inst_pkg.sv ====
`default_nettype none

package rv_inst_pkg;

  // rv32 major opcodes seen by the fetch unit.
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,
    OP_MISC_MEM = 7'b000_1111,
    OP_OP_IMM   = 7'b001_0011,
    OP_AUIPC    = 7'b001_0111,
    OP_STORE    = 7'b010_0011,
    OP_OP       = 7'b011_0011,
    OP_LUI      = 7'b011_0111,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011
  } opcode_e;

  typedef struct packed {
    logic [24:0] upper;
    opcode_e     opcode;
  } inst_base_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } inst_itype_t;

  // one instruction word, read either way.
  typedef union packed {
    inst_base_t  base;
    inst_itype_t itype;
  } inst_u;

  // what the fetch unit does after an instruction is taken.
  typedef enum logic [1:0] {
    SEQ  = 2'd0,
    CTRL = 2'd1,
    LOAD = 2'd2
  } fetch_class_e;

endpackage

`default_nettype wire

// ==== verilog/ibus_pkg.sv ====
`default_nettype none

package ibus_pkg;

  // refill sequencer of the instruction cache.
  // each beat has a request cycle and a wait for the response.
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    REQ0  = 3'd1,
    WAIT0 = 3'd2,
    REQ1  = 3'd3,
    WAIT1 = 3'd4
  } refill_state_e;

  // the word index of each refill beat follows from its state.
  // REQ0 and WAIT0 carry the line base, REQ1 and WAIT1 the next word.
  // only one read is outstanding on the bus.

endpackage

`default_nettype wire

// ==== verilog/inst_predecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_predecode (
  input  rv_inst_pkg::inst_u        inst_i,
  output rv_inst_pkg::fetch_class_e class_o,
  output logic                      fence_i_o
);
  import rv_inst_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;

  assign opcode = inst_i.base.opcode;
  assign funct3 = inst_i.itype.funct3;

  // anything that may change the flow stalls until redirect.
  always_comb begin
    case (opcode)
      OP_JAL: begin
        class_o = CTRL;
      end
      OP_JALR: begin
        class_o = CTRL;
      end
      OP_BRANCH: begin
        class_o = CTRL;
      end
      OP_SYSTEM: begin
        class_o = CTRL;
      end
      OP_LOAD: begin
        class_o = LOAD;
      end
      default: begin
        class_o = SEQ;
      end
    endcase
  end

  // fence is funct3 0, fence.i is funct3 1.
  always_comb begin
    fence_i_o = 1'b0;
    if (opcode == OP_MISC_MEM) begin
      fence_i_o = (funct3 == 3'b001);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/l1i_cache.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ifu_macros.svh"

module l1i_cache (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`IFU_XLEN-1:0] pc_i,
  input  logic                 flush_i,
  output logic                 hit_o,
  output logic [`IFU_XLEN-1:0] data_o,
  output logic                 ar_valid_o,
  output logic [`IFU_XLEN-1:0] ar_addr_o,
  input  logic                 r_valid_i,
  input  logic [`IFU_XLEN-1:0] r_data_i
);
  import ibus_pkg::*;

  logic [`L1I_TAG_BITS-1:0]  pc_tag;
  logic [`L1I_SET_BITS-1:0]  pc_idx;
  logic [`L1I_WORD_BITS-1:0] pc_word;

  logic [`IFU_XLEN-1:0]     data_mem [`L1I_SETS][`L1I_WORDS];
  logic [`L1I_TAG_BITS-1:0] tag_mem  [`L1I_SETS];
  logic [`L1I_SETS-1:0]     valid_q;

  refill_state_e state_q;
  logic          miss;
  logic          beat_done;
  logic          last_beat;

  // line address of the refill in progress.
  logic [`L1I_TAG_BITS+`L1I_SET_BITS-1:0] line_q;
  logic [`L1I_TAG_BITS-1:0]               line_tag;
  logic [`L1I_SET_BITS-1:0]               line_idx;
  logic [`L1I_WORD_BITS-1:0]              beat_word;

  assign pc_tag  = pc_i[`IFU_XLEN-1:`L1I_TAG_LSB];
  assign pc_idx  = pc_i[`L1I_TAG_LSB-1:`L1I_IDX_LSB];
  assign pc_word = pc_i[`L1I_IDX_LSB-1:2];

  assign line_tag = line_q[`L1I_TAG_BITS+`L1I_SET_BITS-1:`L1I_SET_BITS];
  assign line_idx = line_q[`L1I_SET_BITS-1:0];

  // a flush in flight already counts as invalid.
  assign hit_o  = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag) && !flush_i;
  assign data_o = data_mem[pc_idx][pc_word];

  assign miss = (state_q == IDLE) && !hit_o;

  // second beat fetches the word after the line base.
  always_comb begin
    beat_word = '0;
    beat_word[0] = (state_q == REQ1) || (state_q == WAIT1);
  end

  assign beat_done = r_valid_i && ((state_q == WAIT0) || (state_q == WAIT1));
  assign last_beat = r_valid_i && (state_q == WAIT1);

  // request is held through the wait for its response.
  assign ar_valid_o = (state_q != IDLE);
  assign ar_addr_o  = {line_q, beat_word, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss) begin
            state_q <= REQ0;
          end
        end
        REQ0: begin
          state_q <= WAIT0;
        end
        WAIT0: begin
          if (r_valid_i) begin
            state_q <= REQ1;
          end
        end
        REQ1: begin
          state_q <= WAIT1;
        end
        WAIT1: begin
          if (r_valid_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // flush wins over a line that completes in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (miss) begin
      valid_q[pc_idx] <= 1'b0;
    end else if (last_beat) begin
      valid_q[line_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      line_q <= {pc_tag, pc_idx};
    end
    if (beat_done) begin
      data_mem[line_idx][beat_word] <= r_data_i;
    end
    if (last_beat) begin
      tag_mem[line_idx] <= line_tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ifu_macros.svh"

module fetch_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      hit_i,
  input  rv_inst_pkg::fetch_class_e class_i,
  input  logic                      fence_i_i,
  input  logic                      ready_i,
  input  logic                      redirect_valid_i,
  input  logic [`IFU_XLEN-1:0]      redirect_pc_i,
  output logic [`IFU_XLEN-1:0]      pc_o,
  output logic                      valid_o,
  output logic                      flush_o
);
  import rv_inst_pkg::*;

  logic [`IFU_XLEN-1:0] pc_q;
  logic [`IFU_XLEN-1:0] pc_d;
  logic                 stall_q;
  logic                 stall_d;
  logic                 flush_q;
  logic                 accept;
  logic                 resume;

  // nothing is offered while waiting for the back end.
  assign valid_o = hit_i && !stall_q;
  assign accept  = valid_o && ready_i;
  assign resume  = stall_q && redirect_valid_i;

  assign pc_o    = pc_q;
  assign flush_o = flush_q;

  always_comb begin
    pc_d    = pc_q;
    stall_d = stall_q;
    if (accept) begin
      case (class_i)
        SEQ: begin
          pc_d = pc_q + `IFU_XLEN'd4;
        end
        default: begin
          // target or load result is known only in the back end.
          stall_d = 1'b1;
        end
      endcase
    end else if (resume) begin
      pc_d    = redirect_pc_i;
      stall_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `IFU_PC_INIT;
      stall_q <= 1'b0;
    end else begin
      pc_q    <= pc_d;
      stall_q <= stall_d;
    end
  end

  // one cycle pulse after fence.i leaves the fetch stage.
  always_ff @(posedge clk) begin
    if (rst) begin
      flush_q <= 1'b0;
    end else begin
      flush_q <= accept && fence_i_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ifetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ifu_macros.svh"

module ifetch_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ready_i,
  input  logic                 redirect_valid_i,
  input  logic [`IFU_XLEN-1:0] redirect_pc_i,
  output rv_inst_pkg::inst_u   inst_o,
  output logic [`IFU_XLEN-1:0] pc_o,
  output logic                 valid_o,
  output logic                 ar_valid_o,
  output logic [`IFU_XLEN-1:0] ar_addr_o,
  input  logic                 r_valid_i,
  input  logic [`IFU_XLEN-1:0] r_data_i
);
  import rv_inst_pkg::*;

  logic [`IFU_XLEN-1:0] fetch_pc;
  logic                 hit;
  inst_u                hit_data;
  fetch_class_e         fetch_class;
  logic                 fence_i;
  logic                 flush;

  l1i_cache i_cache (
    .clk        (clk),
    .rst        (rst),
    .pc_i       (fetch_pc),
    .flush_i    (flush),
    .hit_o      (hit),
    .data_o     (hit_data),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i)
  );

  inst_predecode i_predecode (
    .inst_i    (hit_data),
    .class_o   (fetch_class),
    .fence_i_o (fence_i)
  );

  fetch_ctrl i_fetch_ctrl (
    .clk              (clk),
    .rst              (rst),
    .hit_i            (hit),
    .class_i          (fetch_class),
    .fence_i_i        (fence_i),
    .ready_i          (ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .pc_o             (fetch_pc),
    .valid_o          (valid_o),
    .flush_o          (flush)
  );

  assign inst_o = hit_data;
  assign pc_o   = fetch_pc;

endmodule

`default_nettype wire

// ==== dv/ibus_mem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ifu_macros.svh"

module ibus_mem (
  input  logic                 clk,
  input  logic                 ar_valid_i,
  input  logic [`IFU_XLEN-1:0] ar_addr_i,
  output logic                 r_valid_o,
  output logic [`IFU_XLEN-1:0] r_data_o
);

  localparam int DEPTH = 256;
  localparam logic [`IFU_XLEN-1:0] BASE = `IFU_PC_INIT;

  logic [`IFU_XLEN-1:0] mem [DEPTH];
  logic [`IFU_XLEN-1:0] addr_q;
  logic                 busy_q;
  logic [1:0]           delay_q;

  // words never written hold their own inverted byte address.
  initial begin
    r_valid_o = 1'b0;
    r_data_o  = '0;
    busy_q    = 1'b0;
    delay_q   = '0;
    addr_q    = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = ~(BASE + 4 * i);
    end
  end

  task automatic write_word(input logic [`IFU_XLEN-1:0] addr,
                            input logic [`IFU_XLEN-1:0] data);
    mem[addr[9:2]] = data;
  endtask

  // the response comes two cycles after the request is taken.
  always @(negedge clk) begin
    r_valid_o <= 1'b0;
    if (busy_q) begin
      if (delay_q == 0) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[addr_q[9:2]];
        busy_q    <= 1'b0;
      end else begin
        delay_q <= delay_q - 1'b1;
      end
    end else if (ar_valid_i) begin
      addr_q  <= ar_addr_i;
      busy_q  <= 1'b1;
      delay_q <= 2'd1;
    end
  end

endmodule

`default_nettype wire

// ==== dv/ifetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ifu_macros.svh"

module ifetch_tb;
  import rv_inst_pkg::*;
  import ibus_pkg::*;

  localparam int NUM_ROWS       = 16;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;
  localparam int LINE_SHIFT     = `L1I_WORD_BITS + 2;

  typedef struct packed {
    logic [`IFU_XLEN-1:0] addr;
    logic [`IFU_XLEN-1:0] word;
    fetch_class_e         cls;
    logic [`IFU_XLEN-1:0] next_pc;
  } row_t;

  logic                 clk;
  logic                 rst;
  logic                 ready;
  logic                 redirect_valid;
  logic [`IFU_XLEN-1:0] redirect_pc;
  inst_u                inst;
  logic [`IFU_XLEN-1:0] pc;
  logic                 valid;
  logic                 ar_valid;
  logic [`IFU_XLEN-1:0] ar_addr;
  logic                 r_valid;
  logic [`IFU_XLEN-1:0] r_data;

  row_t                 rows [NUM_ROWS];
  logic [`IFU_XLEN-1:0] expected_reads [$];
  logic [`L1I_SETS-1:0] model_valid;
  logic [`IFU_XLEN-1:0] model_tag [`L1I_SETS];
  logic                 ar_valid_prev = 1'b0;
  logic [`IFU_XLEN-1:0] ar_addr_prev  = '0;
  logic [`IFU_XLEN-1:0] want_addr;
  refill_state_e        refill_state;
  integer               seed;
  int                   errors;

  ifetch_top i_dut (
    .clk              (clk),
    .rst              (rst),
    .ready_i          (ready),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .inst_o           (inst),
    .pc_o             (pc),
    .valid_o          (valid),
    .ar_valid_o       (ar_valid),
    .ar_addr_o        (ar_addr),
    .r_valid_i        (r_valid),
    .r_data_i         (r_data)
  );

  ibus_mem i_mem (
    .clk        (clk),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // a line that is missing or holds another tag has to be refilled.
  task automatic predict_refill(input logic [`IFU_XLEN-1:0] addr);
    logic [`IFU_XLEN-1:0] line_addr;
    int                   set_idx;
    line_addr = addr >> LINE_SHIFT;
    set_idx   = line_addr % `L1I_SETS;
    if (!model_valid[set_idx] || model_tag[set_idx] != (line_addr >> `L1I_SET_BITS)) begin
      for (int w = 0; w < `L1I_WORDS; w++) begin
        expected_reads.push_back((line_addr << LINE_SHIFT) + 4 * w);
      end
      model_valid[set_idx] = 1'b1;
      model_tag[set_idx]   = line_addr >> `L1I_SET_BITS;
    end
  endtask

  task automatic check_fetch(input int r);
    if (pc !== rows[r].addr) begin
      $display("FAIL row %0d: pc_o = %h, expected %h", r, pc, rows[r].addr);
      errors++;
    end
    if (inst !== rows[r].word) begin
      $display("FAIL row %0d: inst_o = %h, expected %h", r, inst, rows[r].word);
      errors++;
    end
  endtask

  task automatic check_stalled(input int r);
    if (valid !== 1'b0) begin
      $display("FAIL row %0d: valid_o = %h, expected 0 before redirect", r, valid);
      errors++;
    end
  endtask

  task automatic run_row(input int r);
    int hold;
    int gap;
    hold = $unsigned($random(seed)) % 4;
    gap  = 1 + $unsigned($random(seed)) % 4;
    predict_refill(rows[r].addr);
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    check_fetch(r);
    // the offered instruction holds while ready_i is low.
    repeat (hold) begin
      @(negedge clk);
      if (valid !== 1'b1) begin
        $display("FAIL row %0d: valid_o = %h, expected 1 under back-pressure", r, valid);
        errors++;
      end
      check_fetch(r);
    end
    ready = 1'b1;
    @(negedge clk);
    ready = 1'b0;
    // fence.i empties the whole cache.
    if (rows[r].word[6:0] == OP_MISC_MEM && rows[r].word[14:12] == 3'b001) begin
      model_valid = '0;
    end
    if (rows[r].cls != SEQ) begin
      repeat (gap) begin
        check_stalled(r);
        @(negedge clk);
      end
      check_stalled(r);
      redirect_valid = 1'b1;
      redirect_pc    = rows[r].next_pc;
      @(negedge clk);
      redirect_valid = 1'b0;
    end
  endtask

  // a new read is a rising ar_valid_o or a new address while it stays high.
  always @(negedge clk) begin
    if (ar_valid && (!ar_valid_prev || ar_addr !== ar_addr_prev)) begin
      refill_state = i_dut.i_cache.state_q;
      if (expected_reads.size() == 0) begin
        $display("unexpected bus read of %h in refill state %s", ar_addr, refill_state.name());
        errors++;
      end else begin
        want_addr = expected_reads.pop_front();
        if (ar_addr !== want_addr) begin
          $display("FAIL ar_addr_o = %h, expected %h, refill state %s",
                   ar_addr, want_addr, refill_state.name());
          errors++;
        end
      end
    end
    ar_valid_prev <= ar_valid;
    ar_addr_prev  <= ar_addr;
  end

  initial begin
    seed           = 32'hf40f_b888;
    errors         = 0;
    rst            = 1'b1;
    ready          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    model_valid    = '0;
    // 0x20 shares set 0 with 0x00, 0x0c is jalr so its targets vary.
    rows[0]  = '{`IFU_PC_INIT,  32'h0010_0093, SEQ,  32'h8000_0004};
    rows[1]  = '{32'h8000_0004, 32'h1234_50b7, SEQ,  32'h8000_0008};
    rows[2]  = '{32'h8000_0008, 32'h0020_81b3, SEQ,  32'h8000_000c};
    rows[3]  = '{32'h8000_000c, 32'h0000_8067, CTRL, 32'h8000_0020};
    rows[4]  = '{32'h8000_0020, 32'h0000_a103, LOAD, 32'h8000_0000};
    rows[5]  = '{32'h8000_0000, 32'h0010_0093, SEQ,  32'h8000_0004};
    rows[6]  = '{32'h8000_0004, 32'h1234_50b7, SEQ,  32'h8000_0008};
    rows[7]  = '{32'h8000_0008, 32'h0020_81b3, SEQ,  32'h8000_000c};
    rows[8]  = '{32'h8000_000c, 32'h0000_8067, CTRL, 32'h8000_0010};
    rows[9]  = '{32'h8000_0010, 32'h0000_100f, SEQ,  32'h8000_0014};
    rows[10] = '{32'h8000_0014, 32'h0020_a023, SEQ,  32'h8000_0018};
    rows[11] = '{32'h8000_0018, 32'h0020_8463, CTRL, 32'h8000_0008};
    rows[12] = '{32'h8000_0008, 32'h0020_81b3, SEQ,  32'h8000_000c};
    rows[13] = '{32'h8000_000c, 32'h0000_8067, CTRL, 32'h8000_0008};
    rows[14] = '{32'h8000_0008, 32'h0020_81b3, SEQ,  32'h8000_000c};
    rows[15] = '{32'h8000_000c, 32'h0000_8067, CTRL, 32'h8000_001c};
    @(negedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      i_mem.write_word(rows[r].addr, rows[r].word);
    end
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
    end
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    repeat (8) begin
      @(negedge clk);
    end
    if (expected_reads.size() != 0) begin
      $display("%0d predicted bus reads were never issued", expected_reads.size());
      errors++;
    end
    $display("fetch checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("timeout: fetch did not finish in %0d cycles, errors: %0d", TIMEOUT_CYCLES, errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ifetch.f ====
+incdir+verilog
verilog/rv_inst_pkg.sv
verilog/ibus_pkg.sv
verilog/inst_predecode.sv
verilog/l1i_cache.sv
verilog/fetch_ctrl.sv
verilog/ifetch_top.sv
dv/ibus_mem.sv
dv/ifetch_tb.sv
